/* common/rv_params.svh */
`ifndef RV_PARAMS_SVH
`define RV_PARAMS_SVH

// datapath width
`define CPU_WIDTH 64

// register file geometry
`define REG_ADDR_WIDTH 5
`define REG_DATA_DEPTH 32

// data memory, byte address bits and doubleword count
`define MEM_ADDR_WIDTH 9
`define MEM_DEPTH (1 << (`MEM_ADDR_WIDTH - 3))

`endif

/* common/rv_pkg.sv */
package rv_pkg;

    // decoded instruction opcodes
    typedef enum logic [3:0] {
        OP_ADD  = 4'd0,
        OP_SUB  = 4'd1,
        OP_AND  = 4'd2,
        OP_OR   = 4'd3,
        OP_XOR  = 4'd4,
        OP_ADDW = 4'd5,
        OP_ADDI = 4'd6,
        OP_LD   = 4'd7,
        OP_LW   = 4'd8,
        OP_LWU  = 4'd9,
        OP_LH   = 4'd10,
        OP_SD   = 4'd11,
        OP_SW   = 4'd12,
        OP_SH   = 4'd13
    } op_e;

    // alu functions
    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4
    } alu_op_e;

    // write-back extension applied in the register file
    typedef enum logic [1:0] {
        EXT_NONE   = 2'd0,  // full doubleword
        EXT_SEXT_W = 2'd1,  // addw, lw
        EXT_ZEXT_W = 2'd2,  // lwu
        EXT_SEXT_H = 2'd3   // lh
    } wb_ext_e;

    // memory access size
    typedef enum logic [1:0] {
        SIZE_D = 2'd0,
        SIZE_W = 2'd1,
        SIZE_H = 2'd2
    } mem_size_e;

endpackage

/* reg_file/reg_file.sv */
`include "rv_params.svh"

module reg_file import rv_pkg::*; (
    input  logic                       clk,
    input  logic                       rst_n,

    input  logic                       reg_wen,    // write back this cycle
    input  logic                       load_sel,   // memory data instead of alu
    input  logic [`REG_ADDR_WIDTH-1:0] rd,
    input  logic [`REG_ADDR_WIDTH-1:0] rs1,
    input  logic [`REG_ADDR_WIDTH-1:0] rs2,
    input  logic [`CPU_WIDTH-1:0]      alu_result,
    input  logic [`CPU_WIDTH-1:0]      load_data,  // already aligned to bit 0
    input  wb_ext_e                    wb_ext,

    output logic [`CPU_WIDTH-1:0]      rs1_data,
    output logic [`CPU_WIDTH-1:0]      rs2_data,
    output logic [`CPU_WIDTH-1:0]      wb_data
);

    logic [`CPU_WIDTH-1:0] regs [0:`REG_DATA_DEPTH-1];
    logic [`CPU_WIDTH-1:0] raw_value;  // before extension
    logic [`CPU_WIDTH-1:0] ext_value;

    assign raw_value = load_sel ? load_data : alu_result;

    // narrow and re-extend the result for word and halfword ops
    always_comb begin
        case (wb_ext)
            EXT_SEXT_W: ext_value = {{32{raw_value[31]}}, raw_value[31:0]};
            EXT_ZEXT_W: ext_value = {32'b0, raw_value[31:0]};
            EXT_SEXT_H: ext_value = {{48{raw_value[15]}}, raw_value[15:0]};
            default:    ext_value = raw_value;
        endcase
    end

    // exported so that x0 writes can be observed
    assign wb_data = reg_wen ? ext_value : '0;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `REG_DATA_DEPTH; i++) begin
                regs[i] <= '0;
            end
        end else if (reg_wen && (rd != '0)) begin  // x0 is read only
            regs[rd] <= ext_value;
        end
    end

    // read port 1
    always_comb begin
        if (rs1 == '0)
            rs1_data = '0;
        else
            rs1_data = regs[rs1];
    end

    // read port 2
    always_comb begin
        if (rs2 == '0)
            rs2_data = '0;
        else
            rs2_data = regs[rs2];
    end

endmodule

/* src/op_decode.sv */
module op_decode import rv_pkg::*; (
    input  op_e       op,
    input  logic      valid,

    output alu_op_e   alu_op,
    output logic      use_imm,   // immediate as second operand
    output logic      load_sel,  // write back memory data
    output logic      reg_wen,
    output logic      mem_wen,
    output wb_ext_e   wb_ext,
    output mem_size_e mem_size
);

    logic is_store;

    always_comb begin
        alu_op   = ALU_ADD;
        use_imm  = 1'b0;
        load_sel = 1'b0;
        is_store = 1'b0;
        wb_ext   = EXT_NONE;
        mem_size = SIZE_D;
        case (op)
            OP_ADD:  alu_op = ALU_ADD;
            OP_SUB:  alu_op = ALU_SUB;
            OP_AND:  alu_op = ALU_AND;
            OP_OR:   alu_op = ALU_OR;
            OP_XOR:  alu_op = ALU_XOR;
            OP_ADDW: wb_ext = EXT_SEXT_W;
            OP_ADDI: use_imm = 1'b1;
            OP_LD: begin
                use_imm  = 1'b1;
                load_sel = 1'b1;
            end
            OP_LW: begin
                use_imm  = 1'b1;
                load_sel = 1'b1;
                wb_ext   = EXT_SEXT_W;
            end
            OP_LWU: begin
                use_imm  = 1'b1;
                load_sel = 1'b1;
                wb_ext   = EXT_ZEXT_W;
            end
            OP_LH: begin
                use_imm  = 1'b1;
                load_sel = 1'b1;
                wb_ext   = EXT_SEXT_H;
            end
            OP_SD: begin
                use_imm  = 1'b1;
                is_store = 1'b1;
            end
            OP_SW: begin
                use_imm  = 1'b1;
                is_store = 1'b1;
                mem_size = SIZE_W;
            end
            OP_SH: begin
                use_imm  = 1'b1;
                is_store = 1'b1;
                mem_size = SIZE_H;
            end
            default: ;
        endcase
    end

    // stores never write back
    assign reg_wen = valid && !is_store;
    assign mem_wen = valid && is_store;

endmodule

/* src/alu.sv */
`include "rv_params.svh"

module alu import rv_pkg::*; (
    input  alu_op_e               alu_op,
    input  logic                  use_imm,
    input  logic [`CPU_WIDTH-1:0] rs1_data,
    input  logic [`CPU_WIDTH-1:0] rs2_data,
    input  logic [31:0]           imm,

    output logic [`CPU_WIDTH-1:0] alu_result
);

    logic [`CPU_WIDTH-1:0] imm_sext;
    logic [`CPU_WIDTH-1:0] op_a;
    logic [`CPU_WIDTH-1:0] op_b;

    // immediate is always signed
    assign imm_sext = {{(`CPU_WIDTH - 32){imm[31]}}, imm};

    assign op_a = rs1_data;
    assign op_b = use_imm ? imm_sext : rs2_data;  // addi, loads, stores

    // word ops run full width, reg_file narrows them afterwards
    always_comb begin
        case (alu_op)
            ALU_ADD: alu_result = op_a + op_b;
            ALU_SUB: alu_result = op_a - op_b;
            ALU_AND: alu_result = op_a & op_b;
            ALU_OR:  alu_result = op_a | op_b;
            ALU_XOR: alu_result = op_a ^ op_b;
            default: alu_result = '0;
        endcase
    end

endmodule

/* src/data_mem.sv */
`include "rv_params.svh"

module data_mem import rv_pkg::*; (
    input  logic                  clk,
    input  logic                  mem_wen,
    input  logic [`CPU_WIDTH-1:0] addr,        // byte address
    input  logic [`CPU_WIDTH-1:0] store_data,  // rs2, lowest bytes first
    input  mem_size_e             mem_size,

    output logic [`CPU_WIDTH-1:0] load_data
);

    logic [`CPU_WIDTH-1:0] mem [0:`MEM_DEPTH-1];

    logic [`MEM_ADDR_WIDTH-4:0] word_idx;
    logic [2:0]                 byte_off;
    logic [5:0]                 bit_shift;
    logic [7:0]                 byte_mask;
    logic [`CPU_WIDTH-1:0]      store_lanes;

    assign word_idx  = addr[`MEM_ADDR_WIDTH-1:3];
    assign byte_off  = addr[2:0];
    assign bit_shift = {byte_off, 3'b000};

    // lanes touched by the store, alignment assumed
    always_comb begin
        case (mem_size)
            SIZE_W:  byte_mask = 8'h0f << byte_off;
            SIZE_H:  byte_mask = 8'h03 << byte_off;
            default: byte_mask = 8'hff;
        endcase
    end

    assign store_lanes = store_data << bit_shift;

    always_ff @(posedge clk) begin
        if (mem_wen) begin
            for (int b = 0; b < 8; b++) begin
                if (byte_mask[b])
                    mem[word_idx][b*8 +: 8] <= store_lanes[b*8 +: 8];
            end
        end
    end

    // addressed bytes land at bit 0, upper bits are trimmed on write back
    assign load_data = mem[word_idx] >> bit_shift;

endmodule

/* src/exec_core.sv */
`include "rv_params.svh"

module exec_core import rv_pkg::*; (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       valid,
    input  op_e                        op,
    input  logic [`REG_ADDR_WIDTH-1:0] rd,
    input  logic [`REG_ADDR_WIDTH-1:0] rs1,
    input  logic [`REG_ADDR_WIDTH-1:0] rs2,
    input  logic [31:0]                imm,

    output logic [`CPU_WIDTH-1:0]      wb_data,
    output logic                       wb_en
);

    alu_op_e               alu_op;
    wb_ext_e               wb_ext;
    mem_size_e             mem_size;
    logic                  use_imm;
    logic                  load_sel;
    logic                  reg_wen;
    logic                  mem_wen;
    logic [`CPU_WIDTH-1:0] rs1_data;
    logic [`CPU_WIDTH-1:0] rs2_data;
    logic [`CPU_WIDTH-1:0] alu_result;  // also the memory address
    logic [`CPU_WIDTH-1:0] load_data;

    op_decode u_op_decode (
        .op       (op),
        .valid    (valid),
        .alu_op   (alu_op),
        .use_imm  (use_imm),
        .load_sel (load_sel),
        .reg_wen  (reg_wen),
        .mem_wen  (mem_wen),
        .wb_ext   (wb_ext),
        .mem_size (mem_size)
    );

    reg_file u_reg_file (
        .clk        (clk),
        .rst_n      (rst_n),
        .reg_wen    (reg_wen),
        .load_sel   (load_sel),
        .rd         (rd),
        .rs1        (rs1),
        .rs2        (rs2),
        .alu_result (alu_result),
        .load_data  (load_data),
        .wb_ext     (wb_ext),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .wb_data    (wb_data)
    );

    alu u_alu (
        .alu_op     (alu_op),
        .use_imm    (use_imm),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .imm        (imm),
        .alu_result (alu_result)
    );

    data_mem u_data_mem (
        .clk        (clk),
        .mem_wen    (mem_wen),
        .addr       (alu_result),
        .store_data (rs2_data),
        .mem_size   (mem_size),
        .load_data  (load_data)
    );

    assign wb_en = reg_wen;

endmodule

/* testbench/exec_core_checker.sv */
`include "rv_params.svh"

module exec_core_checker (
    input logic                       clk,
    input logic                       rst_n,
    input logic [`REG_ADDR_WIDTH-1:0] rs1,
    input logic [`REG_ADDR_WIDTH-1:0] rs2,
    input logic [`CPU_WIDTH-1:0]      rs1_data,
    input logic [`CPU_WIDTH-1:0]      rs2_data,
    input logic                       reg_wen,
    input logic                       mem_wen
);
    timeunit 1ns;
    timeprecision 100ps;

    // x0 is hardwired on both read ports
    x0_reads_zero: assert property (@(posedge clk) disable iff (!rst_n)
        ((rs1 == '0) |-> (rs1_data == '0)) and ((rs2 == '0) |-> (rs2_data == '0)))
        else $error("x0 read returned a nonzero value");

    // same address one cycle after a slot with no write back
    regs_hold_without_write: assert property (@(posedge clk) disable iff (!rst_n)
        !reg_wen ##1 ($stable(rs1) && $stable(rs2)) |-> ($stable(rs1_data) && $stable(rs2_data)))
        else $error("register changed while reg_wen was low");

    store_excludes_writeback: assert property (@(posedge clk) disable iff (!rst_n)
        !(mem_wen && reg_wen))
        else $error("mem_wen and reg_wen high in the same cycle");

endmodule

// exec_core holds both the register file ports and the memory strobe
bind exec_core exec_core_checker u_checker (
    .clk      (clk),
    .rst_n    (rst_n),
    .rs1      (rs1),
    .rs2      (rs2),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .reg_wen  (reg_wen),
    .mem_wen  (mem_wen)
);

/* testbench/exec_core_tb.sv */
`include "rv_params.svh"

module exec_core_tb import rv_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    typedef struct {
        logic                       vld;
        op_e                        op;
        logic [`REG_ADDR_WIDTH-1:0] rd;
        logic [`REG_ADDR_WIDTH-1:0] rs1;
        logic [`REG_ADDR_WIDTH-1:0] rs2;
        logic [31:0]                imm;
        logic [`CPU_WIDTH-1:0]      exp_data;
        logic                       exp_en;
    } row_t;

    logic                       clk;
    logic                       rst_n;
    logic                       valid;
    op_e                        op;
    logic [`REG_ADDR_WIDTH-1:0] rd;
    logic [`REG_ADDR_WIDTH-1:0] rs1;
    logic [`REG_ADDR_WIDTH-1:0] rs2;
    logic [31:0]                imm;
    logic [`CPU_WIDTH-1:0]      wb_data;
    logic                       wb_en;

    row_t rows[$];
    int   row_errors;
    int   pass_count;
    int   fail_count;
    bit   reset_ok;

    exec_core UUT (.clk(clk), .rst_n(rst_n), .valid(valid), .op(op), .rd(rd), .rs1(rs1),
                   .rs2(rs2), .imm(imm), .wb_data(wb_data), .wb_en(wb_en));

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (4) @(posedge clk);
        #10 rst_n = 1'b1;
    end

    function automatic logic [`CPU_WIDTH-1:0] sext32(input logic [31:0] x);
        return {{32{x[31]}}, x};
    endfunction

    function automatic logic [`CPU_WIDTH-1:0] sext16(input logic [15:0] x);
        return {{48{x[15]}}, x};
    endfunction

    task automatic add_row(input logic vld, input op_e o, input logic [4:0] d,
                           input logic [4:0] s1, input logic [4:0] s2, input logic [31:0] im,
                           input logic [`CPU_WIDTH-1:0] exp_d, input logic exp_e);
        row_t r;
        r.vld = vld;
        r.op = o;
        r.rd = d;
        r.rs1 = s1;
        r.rs2 = s2;
        r.imm = im;
        r.exp_data = exp_d;
        r.exp_en = exp_e;
        rows.push_back(r);
    endtask

    task automatic build_table();
        logic [31:0]           rnd1;
        logic [31:0]           rnd2;
        logic [`CPU_WIDTH-1:0] v1;
        logic [`CPU_WIDTH-1:0] v2;
        logic [`CPU_WIDTH-1:0] v10;
        logic [`CPU_WIDTH-1:0] v12;
        logic [`CPU_WIDTH-1:0] v14;
        logic [`CPU_WIDTH-1:0] mem;
        rnd1 = $urandom;
        rnd2 = $urandom;
        v1 = 64'h123;
        v2 = sext32(32'hffff_fffb);
        v10 = sext32(32'h7fff_ffff + 32'h1);  // addw crosses 2^31
        v12 = sext32(rnd1);
        v14 = v10 ^ v12;
        add_row(1'b1, OP_ADD,  5'd3,  5'd7,  5'd0,  32'h0,         64'h0,   1'b1);
        add_row(1'b1, OP_ADDI, 5'd1,  5'd0,  5'd0,  32'h123,       v1,      1'b1);
        add_row(1'b1, OP_ADDI, 5'd2,  5'd0,  5'd0,  32'hffff_fffb, v2,      1'b1);
        add_row(1'b1, OP_ADD,  5'd3,  5'd1,  5'd2,  32'h0,         v1 + v2, 1'b1);
        add_row(1'b1, OP_SUB,  5'd4,  5'd1,  5'd2,  32'h0,         v1 - v2, 1'b1);
        add_row(1'b1, OP_AND,  5'd5,  5'd1,  5'd2,  32'h0,         v1 & v2, 1'b1);
        add_row(1'b1, OP_OR,   5'd6,  5'd1,  5'd2,  32'h0,         v1 | v2, 1'b1);
        add_row(1'b1, OP_XOR,  5'd7,  5'd1,  5'd2,  32'h0,         v1 ^ v2, 1'b1);
        add_row(1'b1, OP_ADDI, 5'd8,  5'd0,  5'd0,  32'h7fff_ffff, 64'h7fff_ffff, 1'b1);
        add_row(1'b1, OP_ADDI, 5'd9,  5'd0,  5'd0,  32'h1,         64'h1,   1'b1);
        add_row(1'b1, OP_ADDW, 5'd10, 5'd8,  5'd9,  32'h0,         v10,     1'b1);
        add_row(1'b1, OP_ADDI, 5'd0,  5'd1,  5'd0,  32'h5,         v1 + 64'h5, 1'b1);
        add_row(1'b1, OP_ADD,  5'd11, 5'd1,  5'd0,  32'h0,         v1,      1'b1);  // x0 still 0
        add_row(1'b1, OP_ADDI, 5'd12, 5'd0,  5'd0,  rnd1,          v12,     1'b1);
        add_row(1'b1, OP_ADDI, 5'd13, 5'd12, 5'd0,  rnd2,          v12 + sext32(rnd2), 1'b1);
        add_row(1'b1, OP_XOR,  5'd14, 5'd10, 5'd12, 32'h0,         v14,     1'b1);
        add_row(1'b1, OP_SD,   5'd0,  5'd0,  5'd14, 32'h40,        64'h0,   1'b0);
        add_row(1'b1, OP_LD,   5'd15, 5'd0,  5'd0,  32'h40,        v14,     1'b1);
        mem = {v1[31:0], v14[31:0]};  // upper word replaced
        add_row(1'b1, OP_SW,   5'd0,  5'd0,  5'd1,  32'h44,        64'h0,   1'b0);
        mem = {mem[63:32], v2[15:0], mem[15:0]};  // lanes 2 and 3
        add_row(1'b1, OP_SH,   5'd0,  5'd0,  5'd2,  32'h42,        64'h0,   1'b0);
        add_row(1'b1, OP_LD,   5'd16, 5'd0,  5'd0,  32'h40,        mem,     1'b1);
        add_row(1'b1, OP_LW,   5'd17, 5'd0,  5'd0,  32'h40,        sext32(mem[31:0]), 1'b1);
        add_row(1'b1, OP_LWU,  5'd18, 5'd0,  5'd0,  32'h40,        {32'h0, mem[31:0]}, 1'b1);
        add_row(1'b1, OP_LW,   5'd19, 5'd0,  5'd0,  32'h44,        sext32(mem[63:32]), 1'b1);
        add_row(1'b1, OP_LH,   5'd20, 5'd0,  5'd0,  32'h42,        sext16(mem[31:16]), 1'b1);
        add_row(1'b1, OP_LH,   5'd21, 5'd0,  5'd0,  32'h40,        sext16(mem[15:0]), 1'b1);
        add_row(1'b0, OP_ADDI, 5'd1,  5'd1,  5'd3,  32'h555,       64'h0,   1'b0);  // idle slot
        add_row(1'b0, OP_SD,   5'd0,  5'd1,  5'd3,  32'h40,        64'h0,   1'b0);
        add_row(1'b1, OP_ADD,  5'd22, 5'd1,  5'd0,  32'h0,         v1,      1'b1);
        add_row(1'b1, OP_LD,   5'd23, 5'd0,  5'd0,  32'h40,        mem,     1'b1);
    endtask

    task automatic check_data(input int row, input logic [`CPU_WIDTH-1:0] actual,
                              input logic [`CPU_WIDTH-1:0] expected);
        if (actual !== expected) begin
            $display("[ERROR] %0t row %0d wb_data %h, expected %h", $time, row, actual, expected);
            row_errors++;
        end
    endtask

    task automatic check_enable(input int row, input logic actual, input logic expected);
        if (actual !== expected) begin
            $display("[ERROR] %0t row %0d wb_en %b, expected %b", $time, row, actual, expected);
            row_errors++;
        end
    endtask

    task automatic wait_reset_release(output bit ok);
        int cycles;
        cycles = 0;
        while (rst_n !== 1'b1 && cycles < 20) begin
            @(posedge clk);
            cycles++;
        end
        ok = (rst_n === 1'b1);
    endtask

    task automatic run_table();
        row_t r;
        foreach (rows[i]) begin
            r = rows[i];
            @(posedge clk);
            #10;
            valid = r.vld;
            op = r.op;
            rd = r.rd;
            rs1 = r.rs1;
            rs2 = r.rs2;
            imm = r.imm;
            #80;  // just ahead of the next edge
            row_errors = 0;
            check_data(i, wb_data, r.exp_data);
            check_enable(i, wb_en, r.exp_en);
            if (row_errors == 0) begin
                pass_count++;
                $display("row %0d %s valid=%b ok", i, r.op.name(), r.vld);
            end else begin
                fail_count++;
                $display("row %0d %s valid=%b wrong", i, r.op.name(), r.vld);
            end
        end
        @(posedge clk);
        #10 valid = 1'b0;
    endtask

    initial begin
        valid = 1'b0;
        op = OP_ADD;
        rd = '0;
        rs1 = '0;
        rs2 = '0;
        imm = '0;
        pass_count = 0;
        fail_count = 0;
        void'($urandom(39637));
        build_table();
        wait_reset_release(reset_ok);
        if (reset_ok)
            run_table();
        else
            $display("reset was not released within 20 clock cycles");
        $display("%0d rows run, %0d passed, %0d failed", pass_count + fail_count, pass_count,
                 fail_count);
        if (reset_ok && fail_count == 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

endmodule

/* src.f */
+incdir+common
common/rv_pkg.sv
reg_file/reg_file.sv
src/op_decode.sv
src/alu.sv
src/data_mem.sv
src/exec_core.sv
testbench/exec_core_checker.sv
testbench/exec_core_tb.sv

/* run_sim.sh */
#!/bin/sh
# build with Verilator, run, then decide pass or fail from the simulation log
verilator --binary --timing --assert --timescale 1ns/100ps -f src.f \
    --top-module exec_core_tb --Mdir obj_dir -o exec_core_sim > build.log 2>&1 \
    && ./obj_dir/exec_core_sim > sim.log 2>&1 \
    && ! grep -q "CHECKS FAILED" sim.log \
    && grep -q "ALL CHECKS PASSED" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed, see build.log and sim.log"; exit 1; }
